/* Makefile */
TOP = tb_socket

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* flist.f */
hw/socket_pkg.sv
hw/mmio_bus_if.sv
hw/axi_req_fifo.sv
hw/axi_burst_ctrl.sv
hw/mmio_regs.sv
hw/s_axi_socket_top.sv
sim/socket_properties.sv
sim/tb_socket.sv

/* hw/axi_burst_ctrl.sv */
module axi_burst_ctrl import socket_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  axi_req_t                req,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  logic [AXI_DWIDTH-1:0]   wdata,
  input  logic [AXI_DWIDTH/8-1:0] wstrb,
  input  logic                    wvalid,
  input  logic                    wlast,
  output logic                    wready,
  output logic [AXI_DWIDTH-1:0]   rdata,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    rlast,
  output logic [1:0]              rresp,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [1:0]              bresp,
  mmio_bus_if.ctrl                bus
);

  burst_state_e           state;
  burst_state_e           state_next;
  logic [WORD_AWIDTH-1:0] base_addr;
  logic [7:0]             len;
  logic [7:0]             beat_cnt;
  logic                   req_fire;
  logic                   wfire;
  logic                   rfire;
  logic                   bfire;

  assign req_ready = (state == IDLE);
  assign wready    = (state == W_DATA);
  assign bvalid    = (state == W_RESP);
  assign rvalid    = (state == R_DATA);

  assign req_fire = req_valid & req_ready;
  assign wfire    = wvalid & wready;
  assign rfire    = rvalid & rready;
  assign bfire    = bvalid & bready;

  // beat count is len + 1
  assign rlast = rvalid & (beat_cnt == len);
  assign rresp = RESP_OKAY;
  assign bresp = RESP_OKAY;
  assign rdata = AXI_DWIDTH'(bus.rdata);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_fire) begin
          state_next = req.is_write ? W_DATA : R_DATA;
        end
      end
      W_DATA: begin
        if (wfire && wlast) begin
          state_next = W_RESP;
        end
      end
      W_RESP: begin
        if (bfire) begin
          state_next = IDLE;
        end
      end
      R_DATA: begin
        if (rfire && rlast) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == IDLE) begin
        beat_cnt <= '0;
      end else if (wfire || rfire) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // burst base and length, loaded when a request leaves the queue
  always_ff @(posedge clk) begin
    if (req_fire) begin
      base_addr <= req.addr;
      len       <= req.len;
    end
  end

  // incrementing bursts only
  assign bus.beat_addr  = base_addr + WORD_AWIDTH'(beat_cnt);
  assign bus.wr         = wfire;
  assign bus.wdata      = wdata[31:0];
  assign bus.wstrb      = wstrb[3:0];
  assign bus.rd         = rfire;
  assign bus.first_beat = (beat_cnt == 8'd0);

endmodule

/* hw/axi_req_fifo.sv */
module axi_req_fifo import socket_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [AXI_AWIDTH-1:0] awaddr,
  input  logic [AXI_AWIDTH-1:0] araddr,
  input  logic [7:0]            awlen,
  input  logic [7:0]            arlen,
  input  logic                  awvalid,
  input  logic                  arvalid,
  output logic                  awready,
  output logic                  arready,
  output axi_req_t              req,
  output logic                  req_valid,
  input  logic                  req_ready
);

  axi_req_t                 mem [2**FIFO_LOGDEPTH];
  axi_req_t                 enq_req;
  logic [FIFO_LOGDEPTH-1:0] wr_ptr;
  logic [FIFO_LOGDEPTH-1:0] rd_ptr;
  logic [FIFO_LOGDEPTH:0]   count;
  logic                     full;
  logic                     enq;
  logic                     deq;

  // top bit of count set only at depth
  assign full = count[FIFO_LOGDEPTH];

  // write wins, so AR waits while AW is offered
  assign awready = ~full;
  assign arready = ~full & ~awvalid;

  assign enq = (awvalid | arvalid) & ~full;
  assign deq = req_valid & req_ready;

  assign enq_req.addr     = awvalid ? awaddr[AXI_AWIDTH-1:LOG2_BYTES]
                                    : araddr[AXI_AWIDTH-1:LOG2_BYTES];
  assign enq_req.len      = awvalid ? awlen : arlen;
  assign enq_req.is_write = awvalid;

  assign req       = mem[rd_ptr];
  assign req_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (enq) begin
      mem[wr_ptr] <= enq_req;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{FIFO_LOGDEPTH{1'b0}}, enq} - {{FIFO_LOGDEPTH{1'b0}}, deq};
    end
  end

endmodule

/* hw/mmio_bus_if.sv */
interface mmio_bus_if import socket_pkg::*; ();

  // base plus beat index
  logic [WORD_AWIDTH-1:0] beat_addr;
  logic                   wr;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   rd;
  logic                   first_beat;
  // combinational, valid for the current beat
  logic [31:0]            rdata;

  modport ctrl (
    output beat_addr, wr, wdata, wstrb, rd, first_beat,
    input  rdata
  );

  modport regs (
    input  beat_addr, wr, wdata, wstrb, rd, first_beat,
    output rdata
  );

endinterface

/* hw/mmio_regs.sv */
module mmio_regs import socket_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  mmio_bus_if.regs    bus,
  input  logic [31:0] cnt0_value,
  input  logic [31:0] cnt1_value,
  input  logic [31:0] squeue_out_data,
  input  logic        squeue_out_valid,
  output logic        squeue_out_ready,
  output logic [63:0] ext_mem_offset,
  output logic [31:0] socket_inbox,
  output logic        socket_start,
  input  logic        socket_done
);

  mmio_reg_e   reg_sel;
  logic        in_mmio;
  logic [31:0] wmask;
  logic [31:0] wval;
  logic        wr_any;
  logic        csr_we;
  logic        lo_we;
  logic        hi_we;
  logic        inbox_we;
  logic        socket_done_q;
  logic [31:0] csr;
  logic [31:0] offset_lo;
  logic [31:0] offset_hi;
  logic [31:0] inbox;
  logic [31:0] squeue_rdata;

  assign in_mmio = bus.beat_addr[MMIO_REG_SPACE];
  assign reg_sel = mmio_reg_e'(bus.beat_addr[MMIO_REG_SPACE-1:0]);

  assign wmask = {{8{bus.wstrb[3]}}, {8{bus.wstrb[2]}},
                  {8{bus.wstrb[1]}}, {8{bus.wstrb[0]}}};
  assign wval  = bus.wdata & wmask;

  // a beat with no strobes leaves the register alone
  assign wr_any   = bus.wr & (|bus.wstrb) & in_mmio;
  assign csr_we   = wr_any & (reg_sel == SOCKET_CSR);
  assign lo_we    = wr_any & (reg_sel == EXT_MEM_OFFSET_LO);
  assign hi_we    = wr_any & (reg_sel == EXT_MEM_OFFSET_HI);
  assign inbox_we = wr_any & (reg_sel == SOCKET_INBOX);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      socket_done_q <= 1'b0;
    end else begin
      socket_done_q <= socket_done;
    end
  end

  // done clears start and sets the done bit, ahead of any write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr <= '0;
    end else if (socket_done_q) begin
      csr <= {csr[31:2], 1'b1, 1'b0};
    end else if (csr_we) begin
      csr <= wval;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      offset_lo <= '0;
      offset_hi <= '0;
      inbox     <= '0;
    end else begin
      if (lo_we) begin
        offset_lo <= wval;
      end
      if (hi_we) begin
        offset_hi <= wval;
      end
      if (inbox_we) begin
        inbox <= wval;
      end
    end
  end

  // empty status queue reads all ones
  assign squeue_rdata = squeue_out_valid ? squeue_out_data : '1;

  always_comb begin
    bus.rdata = '0;
    if (in_mmio) begin
      case (reg_sel)
        SQUEUE:            bus.rdata = squeue_rdata;
        SOCKET_CSR:        bus.rdata = csr;
        EXT_MEM_OFFSET_LO: bus.rdata = offset_lo;
        EXT_MEM_OFFSET_HI: bus.rdata = offset_hi;
        CNT0:              bus.rdata = cnt0_value;
        CNT1:              bus.rdata = cnt1_value;
        SOCKET_INBOX:      bus.rdata = inbox;
        default:           bus.rdata = '0;
      endcase
    end
  end

  // pop once per burst, on the first beat only
  assign squeue_out_ready = bus.rd & bus.first_beat & in_mmio & (reg_sel == SQUEUE);

  assign ext_mem_offset = {offset_hi, offset_lo};
  assign socket_inbox   = inbox;
  assign socket_start   = csr[0];

endmodule

/* hw/s_axi_socket_top.sv */
module s_axi_socket_top import socket_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  // write address
  input  logic [AXI_AWIDTH-1:0]   s_awaddr,
  input  logic [7:0]              s_awlen,
  input  logic                    s_awvalid,
  output logic                    s_awready,
  // write data
  input  logic [AXI_DWIDTH-1:0]   s_wdata,
  input  logic [AXI_DWIDTH/8-1:0] s_wstrb,
  input  logic                    s_wvalid,
  input  logic                    s_wlast,
  output logic                    s_wready,
  // write response
  output logic [1:0]              s_bresp,
  output logic                    s_bvalid,
  input  logic                    s_bready,
  // read address
  input  logic [AXI_AWIDTH-1:0]   s_araddr,
  input  logic [7:0]              s_arlen,
  input  logic                    s_arvalid,
  output logic                    s_arready,
  // read data
  output logic [AXI_DWIDTH-1:0]   s_rdata,
  output logic                    s_rvalid,
  input  logic                    s_rready,
  output logic                    s_rlast,
  output logic [1:0]              s_rresp,
  // socket side
  input  logic [31:0]             cnt0_value,
  input  logic [31:0]             cnt1_value,
  input  logic [31:0]             squeue_out_data,
  input  logic                    squeue_out_valid,
  output logic                    squeue_out_ready,
  output logic [63:0]             ext_mem_offset,
  output logic [31:0]             socket_inbox,
  output logic                    socket_start,
  input  logic                    socket_done
);

  axi_req_t req;
  logic     req_valid;
  logic     req_ready;

  mmio_bus_if bus ();

  axi_req_fifo i_req_fifo (
    .clk(clk), .arst_n(arst_n),
    .awaddr(s_awaddr), .araddr(s_araddr), .awlen(s_awlen), .arlen(s_arlen),
    .awvalid(s_awvalid), .arvalid(s_arvalid),
    .awready(s_awready), .arready(s_arready),
    .req(req), .req_valid(req_valid), .req_ready(req_ready)
  );

  axi_burst_ctrl i_burst_ctrl (
    .clk(clk), .arst_n(arst_n),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .wdata(s_wdata), .wstrb(s_wstrb), .wvalid(s_wvalid), .wlast(s_wlast),
    .wready(s_wready),
    .rdata(s_rdata), .rvalid(s_rvalid), .rready(s_rready), .rlast(s_rlast),
    .rresp(s_rresp),
    .bvalid(s_bvalid), .bready(s_bready), .bresp(s_bresp),
    .bus(bus.ctrl)
  );

  mmio_regs i_regs (
    .clk(clk), .arst_n(arst_n),
    .bus(bus.regs),
    .cnt0_value(cnt0_value), .cnt1_value(cnt1_value),
    .squeue_out_data(squeue_out_data), .squeue_out_valid(squeue_out_valid),
    .squeue_out_ready(squeue_out_ready),
    .ext_mem_offset(ext_mem_offset), .socket_inbox(socket_inbox),
    .socket_start(socket_start), .socket_done(socket_done)
  );

endmodule

/* hw/socket_pkg.sv */
package socket_pkg;

  // AXI side
  localparam int AXI_AWIDTH = 32;
  localparam int AXI_DWIDTH = 64;
  localparam int LOG2_BYTES = 3;

  // word address bit that selects the register region
  localparam int MMIO_REG_SPACE = 9;
  localparam int WORD_AWIDTH    = AXI_AWIDTH - LOG2_BYTES;

  // request queue holds 2**FIFO_LOGDEPTH entries
  localparam int FIFO_LOGDEPTH = 2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // offsets inside the register region, in words
  typedef enum logic [MMIO_REG_SPACE-1:0] {
    SQUEUE            = 9'd32,
    SOCKET_CSR        = 9'd64,
    EXT_MEM_OFFSET_LO = 9'd65,
    EXT_MEM_OFFSET_HI = 9'd66,
    CNT0              = 9'd71,
    CNT1              = 9'd72,
    SOCKET_INBOX      = 9'd73
  } mmio_reg_e;

  typedef enum logic [1:0] {
    IDLE,
    W_DATA,
    W_RESP,
    R_DATA
  } burst_state_e;

  // one merged AW/AR request
  typedef struct packed {
    logic [WORD_AWIDTH-1:0] addr;
    logic [7:0]             len;
    logic                   is_write;
  } axi_req_t;

endpackage

/* sim/socket_properties.sv */
module socket_properties import socket_pkg::*; (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  s_awvalid,
  input logic                  s_arready,
  input logic                  s_bvalid,
  input logic                  s_bready,
  input logic [AXI_DWIDTH-1:0] s_rdata,
  input logic                  s_rvalid,
  input logic                  s_rready,
  input logic                  s_rlast
);

  int unsigned fail_count = 0;

  // write response stays up until taken
  bvalid_hold: assert property (
    @(posedge clk) disable iff (!arst_n) s_bvalid && !s_bready |=> s_bvalid
  ) else begin
    $error("BVALID dropped before BREADY");
    fail_count++;
  end

  // read beat frozen while stalled
  rbeat_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
      s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rlast)
  ) else begin
    $error("R beat changed while RREADY was low");
    fail_count++;
  end

  rlast_needs_rvalid: assert property (
    @(posedge clk) disable iff (!arst_n) s_rlast |-> s_rvalid
  ) else begin
    $error("RLAST high without RVALID");
    fail_count++;
  end

  // AR waits while a write address is offered
  ar_blocked_by_aw: assert property (
    @(posedge clk) disable iff (!arst_n) s_awvalid |-> !s_arready
  ) else begin
    $error("ARREADY high while AWVALID was high");
    fail_count++;
  end

endmodule

bind s_axi_socket_top socket_properties i_props (.*);

/* sim/tb_socket.sv */
module tb_socket import socket_pkg::*; ();

  localparam int TIMEOUT = 3000;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [31:0] s_awaddr, s_araddr;
  logic [7:0]  s_awlen, s_arlen;
  logic        s_awvalid, s_awready, s_arvalid, s_arready;
  logic [63:0] s_wdata, s_rdata;
  logic [7:0]  s_wstrb;
  logic        s_wvalid, s_wlast, s_wready;
  logic [1:0]  s_bresp, s_rresp;
  logic        s_bvalid, s_bready, s_rvalid, s_rready, s_rlast;
  logic [31:0] cnt0_value, cnt1_value, squeue_out_data, socket_inbox;
  logic        squeue_out_valid, squeue_out_ready, socket_start, socket_done;
  logic [63:0] ext_mem_offset;

  logic        aw_hs, w_hs, b_hs, ar_hs, r_hs, r_last_q;
  logic [31:0] r_data_q;
  logic [1:0]  b_resp_q;
  logic [1:0]  r_resp_q;
  logic [31:0] sq_model [4];
  logic [2:0]  sq_head = 3'd0;
  logic [31:0] rng_state = 32'd16324;
  logic [31:0] rd_beats [$];
  string       test_name;
  int          pop_count = 0;
  int          cycles = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          failed_tests = 0;

  s_axi_socket_top i_dut (.*);

  always #2 clk = ~clk;

  // handshakes as seen at the rising edge
  always @(posedge clk) begin
    aw_hs    <= s_awvalid & s_awready;
    w_hs     <= s_wvalid & s_wready;
    b_hs     <= s_bvalid & s_bready;
    ar_hs    <= s_arvalid & s_arready;
    r_hs     <= s_rvalid & s_rready;
    r_data_q <= s_rdata[31:0];
    r_last_q <= s_rlast;
    b_resp_q <= s_bresp;
    r_resp_q <= s_rresp;
    cycles   <= cycles + 1;
    if (squeue_out_ready) begin
      pop_count <= pop_count + 1;
    end
  end

  // status queue model
  always @(negedge clk) begin
    sq_head <= 3'(pop_count);
  end
  assign squeue_out_valid = (sq_head < 3'd4);
  assign squeue_out_data  = sq_model[sq_head[1:0]];

  always @(negedge clk) begin
    if (cycles >= TIMEOUT) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // register region starts at word 512
  function automatic logic [31:0] reg_addr(input int off);
    return 32'h1000 + 32'(off) * 8;
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    logic [31:0] m;
    m = '0;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      $display("Mismatch %s (%s) expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", test_name, errors - errors_before);
    end
  endtask

  // single beat write, B taken after b_stall cycles
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int b_stall);
    s_awaddr  = addr;
    s_awlen   = 8'd0;
    s_awvalid = 1'b1;
    s_wdata   = {xorshift32(), data};
    s_wstrb   = {4'hf, strb};
    s_wvalid  = 1'b1;
    s_wlast   = 1'b1;
    do @(negedge clk); while (!aw_hs);
    s_awvalid = 1'b0;
    do @(negedge clk); while (!w_hs);
    s_wvalid = 1'b0;
    s_wlast  = 1'b0;
    repeat (b_stall) @(negedge clk);
    s_bready = 1'b1;
    do @(negedge clk); while (!b_hs);
    s_bready = 1'b0;
    check_value("bresp", RESP_OKAY, b_resp_q);
  endtask

  // beats land in rd_beats, rready held low r_stall cycles per beat
  task automatic read_burst(input logic [31:0] addr, input logic [7:0] len, input int r_stall);
    s_araddr  = addr;
    s_arlen   = len;
    s_arvalid = 1'b1;
    do @(negedge clk); while (!ar_hs);
    s_arvalid = 1'b0;
    rd_beats.delete();
    for (int i = 0; i <= int'(len); i++) begin
      repeat (r_stall) @(negedge clk);
      s_rready = 1'b1;
      do @(negedge clk); while (!r_hs);
      s_rready = 1'b0;
      rd_beats.push_back(r_data_q);
      check_value("rlast", i == int'(len), r_last_q);
      check_value("rresp", RESP_OKAY, r_resp_q);
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp_regs [3];
    mmio_reg_e   offs [3];
    int          mark;
    arst_n      = 1'b0;
    s_awaddr    = '0;
    s_awlen     = '0;
    s_awvalid   = 1'b0;
    s_araddr    = '0;
    s_arlen     = '0;
    s_arvalid   = 1'b0;
    s_wdata     = '0;
    s_wstrb     = '0;
    s_wvalid    = 1'b0;
    s_wlast     = 1'b0;
    s_bready    = 1'b0;
    s_rready    = 1'b0;
    socket_done = 1'b0;
    cnt0_value  = xorshift32();
    cnt1_value  = xorshift32();
    for (int i = 0; i < 4; i++) begin
      sq_model[i] = xorshift32();
    end
    offs[0] = EXT_MEM_OFFSET_LO;
    offs[1] = EXT_MEM_OFFSET_HI;
    offs[2] = SOCKET_INBOX;
    exp_regs = '{default: '0};
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    test_name = "regs_strobes";
    mark = errors;
    check_value("start_reset", 0, socket_start);
    // every fourth write has no strobes at all
    for (int i = 0; i < 12; i++) begin
      data = xorshift32();
      strb = (i % 4 == 3) ? 4'h0 : 4'(xorshift32());
      write_word(reg_addr(offs[i % 3]), data, strb, i % 2);
      if (strb != 4'h0) begin
        exp_regs[i % 3] = data & byte_mask(strb);
      end
      read_burst(reg_addr(offs[i % 3]), 8'd0, 0);
      check_value("readback", exp_regs[i % 3], rd_beats[0]);
    end
    check_value("inbox_port", exp_regs[2], socket_inbox);
    check_value("offset_port", {exp_regs[1], exp_regs[0]}, ext_mem_offset);
    finish_test(mark);

    test_name = "burst_len";
    mark = errors;
    read_burst(reg_addr(CNT0), 8'd3, 2);
    check_value("rvalid_after", 0, s_rvalid);
    check_value("beat0", cnt0_value, rd_beats[0]);
    check_value("beat1", cnt1_value, rd_beats[1]);
    check_value("beat2", exp_regs[2], rd_beats[2]);
    check_value("beat3", 0, rd_beats[3]);
    read_burst(reg_addr(CNT1), 8'd0, 0);
    check_value("rvalid_after", 0, s_rvalid);
    check_value("single", cnt1_value, rd_beats[0]);
    finish_test(mark);

    test_name = "csr_start_done";
    mark = errors;
    write_word(reg_addr(SOCKET_CSR), 32'h1, 4'h1, 0);
    check_value("start_high", 1, socket_start);
    socket_done = 1'b1;
    @(negedge clk);
    socket_done = 1'b0;
    // done is registered, csr follows one edge later
    check_value("start_held", 1, socket_start);
    @(negedge clk);
    check_value("start_low", 0, socket_start);
    read_burst(reg_addr(SOCKET_CSR), 8'd0, 0);
    check_value("csr", 32'h2, rd_beats[0]);
    finish_test(mark);

    test_name = "status_queue";
    mark = errors;
    for (int i = 0; i < 4; i++) begin
      read_burst(reg_addr(SQUEUE), 8'(i % 2), 1);
      check_value("head", sq_model[i], rd_beats[0]);
      check_value("pops", i + 1, pop_count);
    end
    read_burst(reg_addr(SQUEUE), 8'd0, 0);
    check_value("empty", 32'hffff_ffff, rd_beats[0]);
    // ready still pulses once on the first beat of the empty read
    check_value("ready_on_empty", 5, pop_count);
    finish_test(mark);

    test_name = "write_priority";
    mark = errors;
    data      = xorshift32();
    s_awaddr  = reg_addr(SOCKET_INBOX);
    s_awlen   = 8'd0;
    s_awvalid = 1'b1;
    s_araddr  = reg_addr(SOCKET_INBOX);
    s_arlen   = 8'd0;
    s_arvalid = 1'b1;
    s_wdata   = {32'h0, data};
    s_wstrb   = 8'hff;
    s_wvalid  = 1'b1;
    s_wlast   = 1'b1;
    s_rready  = 1'b1;
    while (s_awvalid || s_arvalid || s_wvalid) begin
      @(negedge clk);
      if (ar_hs) begin
        check_value("aw_first", 0, s_awvalid);
        s_arvalid = 1'b0;
      end
      if (aw_hs) begin
        s_awvalid = 1'b0;
      end
      if (w_hs) begin
        s_wvalid = 1'b0;
        s_wlast  = 1'b0;
      end
    end
    repeat (3) @(negedge clk);
    check_value("bvalid_held", 1, s_bvalid);
    check_value("bresp", RESP_OKAY, s_bresp);
    s_bready = 1'b1;
    do @(negedge clk); while (!b_hs);
    s_bready = 1'b0;
    do @(negedge clk); while (!r_hs);
    s_rready = 1'b0;
    check_value("read_after_write", data, r_data_q);
    finish_test(mark);

    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, failed_tests, errors, i_dut.i_props.fail_count);
    if (failed_tests == 0 && i_dut.i_props.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
